// File: hart_core_consts.svh
// hart_core constants
// widths, opcodes, funct3 codes and reset values of the RV32I core
`ifndef HART_CORE_CONSTS_SVH
`define HART_CORE_CONSTS_SVH

// data word and register index widths
`define XLEN        32
`define REG_ADDR_W  5

// number of architectural integer registers
`define NUM_REGS    32

// pc value held during and after reset
`define RESET_ADDR  32'h0000_0000

// sequential pc increment for a 4 byte instruction
`define PC_STEP     32'd4

// major opcodes of the instruction classes the core executes
`define OPC_OP      7'b011_0011
`define OPC_OP_IMM  7'b001_0011
`define OPC_LUI     7'b011_0111
`define OPC_BRANCH  7'b110_0011

// funct3 codes of the register and immediate arithmetic groups
`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct3 codes of the conditional branches
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

`endif

// File: hart_pkg.sv
// hart_pkg
// shared datapath types of the core and the control encodings between its blocks
`include "hart_core_consts.svh"

package hart_pkg;

    // one data or address word
    typedef logic [`XLEN-1:0] word_t;

    // one register index
    typedef logic [`REG_ADDR_W-1:0] reg_idx_t;

    // alu operation select
    // the encoding follows the original alu control table so that
    // SUB sits next to ADD and the shifts and compares stay grouped
    typedef enum logic [3:0] {
        ALU_ADD    = 4'b0000,
        ALU_SUB    = 4'b0001,
        ALU_AND    = 4'b0010,
        ALU_OR     = 4'b0011,
        ALU_XOR    = 4'b0100,
        ALU_SLL    = 4'b0101,
        ALU_SRL    = 4'b0110,
        ALU_SRA    = 4'b0111,
        ALU_SLT    = 4'b1000,
        ALU_SLTU   = 4'b1001,
        ALU_PASS_B = 4'b1010
    } alu_op_e;

    // immediate layout carried by the instruction word
    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,
        IMM_I    = 3'd1,
        IMM_S    = 3'd2,
        IMM_B    = 3'd3,
        IMM_U    = 3'd4,
        IMM_J    = 3'd5
    } imm_fmt_e;

    // branch condition that the alu resolves
    // NEVER covers every non-branch instruction
    typedef enum logic [2:0] {
        BR_NEVER = 3'd0,
        BR_EQ    = 3'd1,
        BR_NE    = 3'd2,
        BR_LT    = 3'd3,
        BR_GE    = 3'd4,
        BR_LTU   = 3'd5,
        BR_GEU   = 3'd6
    } br_cond_e;

endpackage

// File: pc_fetch.sv
// pc_fetch
// program counter register with the branch target and sequential next-pc select
`include "hart_core_consts.svh"

module pc_fetch (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            i_branch_taken,
    input  hart_pkg::word_t i_imm,
    output hart_pkg::word_t o_pc,
    output hart_pkg::word_t o_next_pc
);

    hart_pkg::word_t pc_q;
    hart_pkg::word_t branch_target;
    hart_pkg::word_t seq_pc;

    // the branch offset is always even so bit 0 is forced low
    assign branch_target = pc_q + {i_imm[`XLEN-1:1], 1'b0};
    assign seq_pc        = pc_q + `PC_STEP;

    // a taken branch wins over the sequential step
    assign o_next_pc = i_branch_taken ? branch_target : seq_pc;
    assign o_pc      = pc_q;

    //////////////////////////////
    // pc register
    //////////////////////////////

    // one instruction retires per cycle so the pc loads on every edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= `RESET_ADDR;
        end else begin
            pc_q <= o_next_pc;
        end
    end

endmodule

// File: instr_decode.sv
// instr_decode
// main control, alu control and immediate format table merged into one decoder
`include "hart_core_consts.svh"

module instr_decode (
    input  hart_pkg::word_t    i_instr,
    output hart_pkg::reg_idx_t o_rs1,
    output hart_pkg::reg_idx_t o_rs2,
    output hart_pkg::reg_idx_t o_rd,
    output logic               o_rd_wen,
    output logic               o_use_imm,
    output hart_pkg::alu_op_e  o_alu_op,
    output hart_pkg::imm_fmt_e o_imm_fmt,
    output hart_pkg::br_cond_e o_br_cond
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b5;

    assign opcode    = i_instr[6:0];
    assign funct3    = i_instr[14:12];
    assign funct7_b5 = i_instr[30];

    // shared arithmetic decode of the register and immediate groups
    // bit 30 selects SUB only for the register form since ADDI carries
    // immediate bits there, while the shift right group uses it in both forms
    function automatic hart_pkg::alu_op_e arith_op(input logic [2:0] f3,
                                                   input logic       alt,
                                                   input logic       is_reg);
        hart_pkg::alu_op_e op;
        case (f3)
            `F3_ADD:  op = (alt && is_reg) ? hart_pkg::ALU_SUB : hart_pkg::ALU_ADD;
            `F3_SLL:  op = hart_pkg::ALU_SLL;
            `F3_SLT:  op = hart_pkg::ALU_SLT;
            `F3_SLTU: op = hart_pkg::ALU_SLTU;
            `F3_XOR:  op = hart_pkg::ALU_XOR;
            `F3_SR:   op = alt ? hart_pkg::ALU_SRA : hart_pkg::ALU_SRL;
            `F3_OR:   op = hart_pkg::ALU_OR;
            default:  op = hart_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    //////////////////////////////
    // control decode
    //////////////////////////////

    always_comb begin
        // defaults describe a no-op that reads and writes nothing
        o_rs1     = '0;
        o_rs2     = '0;
        o_rd      = '0;
        o_rd_wen  = 1'b0;
        o_use_imm = 1'b0;
        o_alu_op  = hart_pkg::ALU_ADD;
        o_imm_fmt = hart_pkg::IMM_NONE;
        o_br_cond = hart_pkg::BR_NEVER;

        case (opcode)
            `OPC_OP: begin
                o_rs1    = i_instr[19:15];
                o_rs2    = i_instr[24:20];
                o_rd     = i_instr[11:7];
                o_rd_wen = 1'b1;
                o_alu_op = arith_op(funct3, funct7_b5, 1'b1);
            end
            `OPC_OP_IMM: begin
                // shift immediates keep their amount in bits 24:20 of the I field
                o_rs1     = i_instr[19:15];
                o_rd      = i_instr[11:7];
                o_rd_wen  = 1'b1;
                o_use_imm = 1'b1;
                o_imm_fmt = hart_pkg::IMM_I;
                o_alu_op  = arith_op(funct3, funct7_b5, 1'b0);
            end
            `OPC_LUI: begin
                // the alu forwards the upper immediate untouched
                o_rd      = i_instr[11:7];
                o_rd_wen  = 1'b1;
                o_use_imm = 1'b1;
                o_imm_fmt = hart_pkg::IMM_U;
                o_alu_op  = hart_pkg::ALU_PASS_B;
            end
            `OPC_BRANCH: begin
                // rs1 is compared against rs2 and the B immediate feeds the pc adder
                o_rs1     = i_instr[19:15];
                o_rs2     = i_instr[24:20];
                o_imm_fmt = hart_pkg::IMM_B;
                case (funct3)
                    `F3_BEQ:  o_br_cond = hart_pkg::BR_EQ;
                    `F3_BNE:  o_br_cond = hart_pkg::BR_NE;
                    `F3_BLT:  o_br_cond = hart_pkg::BR_LT;
                    `F3_BGE:  o_br_cond = hart_pkg::BR_GE;
                    `F3_BLTU: o_br_cond = hart_pkg::BR_LTU;
                    `F3_BGEU: o_br_cond = hart_pkg::BR_GEU;
                    default:  o_br_cond = hart_pkg::BR_NEVER;
                endcase
            end
            default: begin
                // anything else falls through as a no-op with a sequential pc
            end
        endcase
    end

endmodule

// File: imm_gen.sv
// imm_gen
// assembles and sign-extends the immediate of each RV32I instruction format
module imm_gen (
    input  hart_pkg::word_t    i_instr,
    input  hart_pkg::imm_fmt_e i_fmt,
    output hart_pkg::word_t    o_imm
);

    logic sign;

    // every format takes its sign from bit 31
    assign sign = i_instr[31];

    always_comb begin
        case (i_fmt)
            hart_pkg::IMM_I: begin
                o_imm = {{20{sign}}, i_instr[31:20]};
            end
            hart_pkg::IMM_S: begin
                o_imm = {{20{sign}}, i_instr[31:25], i_instr[11:7]};
            end
            hart_pkg::IMM_B: begin
                // branch offsets are in halfwords so bit 0 is implied zero
                o_imm = {{19{sign}}, i_instr[31], i_instr[7], i_instr[30:25],
                         i_instr[11:8], 1'b0};
            end
            hart_pkg::IMM_U: begin
                // the upper immediate fills bits 31:12 with zeros below
                o_imm = {i_instr[31:12], 12'h000};
            end
            hart_pkg::IMM_J: begin
                o_imm = {{11{sign}}, i_instr[31], i_instr[19:12], i_instr[20],
                         i_instr[30:21], 1'b0};
            end
            default: begin
                o_imm = '0;
            end
        endcase
    end

endmodule

// File: reg_file.sv
// reg_file
// integer register file with two combinational read ports and one write port
`include "hart_core_consts.svh"

module reg_file (
    input  logic               clk,
    input  logic               rst_n,
    input  hart_pkg::reg_idx_t i_rs1,
    input  hart_pkg::reg_idx_t i_rs2,
    input  hart_pkg::reg_idx_t i_rd,
    input  logic               i_wen,
    input  hart_pkg::word_t    i_wdata,
    output hart_pkg::word_t    o_rs1_data,
    output hart_pkg::word_t    o_rs2_data
);

    hart_pkg::word_t regs [`NUM_REGS];

    // x0 never takes a write so its entry stays at the reset value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wen && (i_rd != '0)) begin
            regs[i_rd] <= i_wdata;
        end
    end

    //////////////////////////////
    // read ports
    //////////////////////////////

    // reads see the value from before this cycle's write
    // there is no write-to-read bypass
    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// File: alu.sv
// alu
// arithmetic, logic, shift and compare unit that also resolves the branch condition
module alu (
    input  hart_pkg::alu_op_e  i_op,
    input  hart_pkg::br_cond_e i_br_cond,
    input  hart_pkg::word_t    i_a,
    input  hart_pkg::word_t    i_b,
    output hart_pkg::word_t    o_result,
    output logic               o_taken
);

    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;
    logic       lt_u;

    // only the low five bits of operand b count as the shift amount
    assign shamt = i_b[4:0];

    // one set of comparators serves both SLT and the branches
    assign eq   = (i_a == i_b);
    assign lt_s = ($signed(i_a) < $signed(i_b));
    assign lt_u = (i_a < i_b);

    //////////////////////////////
    // result select
    //////////////////////////////

    always_comb begin
        case (i_op)
            hart_pkg::ALU_ADD:    o_result = i_a + i_b;
            hart_pkg::ALU_SUB:    o_result = i_a - i_b;
            hart_pkg::ALU_AND:    o_result = i_a & i_b;
            hart_pkg::ALU_OR:     o_result = i_a | i_b;
            hart_pkg::ALU_XOR:    o_result = i_a ^ i_b;
            hart_pkg::ALU_SLL:    o_result = i_a << shamt;
            hart_pkg::ALU_SRL:    o_result = i_a >> shamt;
            hart_pkg::ALU_SRA:    o_result = hart_pkg::word_t'($signed(i_a) >>> shamt);
            hart_pkg::ALU_SLT:    o_result = hart_pkg::word_t'(lt_s);
            hart_pkg::ALU_SLTU:   o_result = hart_pkg::word_t'(lt_u);
            hart_pkg::ALU_PASS_B: o_result = i_b;
            default:              o_result = '0;
        endcase
    end

    //////////////////////////////
    // branch resolution
    //////////////////////////////

    // the greater-or-equal conditions are the complements of less-than
    always_comb begin
        case (i_br_cond)
            hart_pkg::BR_EQ:  o_taken = eq;
            hart_pkg::BR_NE:  o_taken = !eq;
            hart_pkg::BR_LT:  o_taken = lt_s;
            hart_pkg::BR_GE:  o_taken = !lt_s;
            hart_pkg::BR_LTU: o_taken = lt_u;
            hart_pkg::BR_GEU: o_taken = !lt_u;
            default:          o_taken = 1'b0;
        endcase
    end

endmodule

// File: hart_core.sv
// hart_core
// single-cycle RV32I integer core with combinational instruction fetch and retire fields
module hart_core (
    input  logic               clk,
    input  logic               rst_n,
    output hart_pkg::word_t    o_imem_raddr,
    input  hart_pkg::word_t    i_imem_rdata,
    output hart_pkg::word_t    o_retire_pc,
    output hart_pkg::word_t    o_retire_next_pc,
    output hart_pkg::reg_idx_t o_retire_rd_waddr,
    output hart_pkg::word_t    o_retire_rd_wdata
);

    hart_pkg::word_t    pc;
    hart_pkg::word_t    next_pc;
    hart_pkg::reg_idx_t rs1;
    hart_pkg::reg_idx_t rs2;
    hart_pkg::reg_idx_t rd;
    logic               rd_wen;
    logic               use_imm;
    hart_pkg::alu_op_e  alu_op;
    hart_pkg::imm_fmt_e imm_fmt;
    hart_pkg::br_cond_e br_cond;
    hart_pkg::word_t    imm;
    hart_pkg::word_t    rs1_data;
    hart_pkg::word_t    rs2_data;
    hart_pkg::word_t    operand_b;
    hart_pkg::word_t    alu_result;
    logic               taken;

    //////////////////////////////
    // fetch and decode
    //////////////////////////////

    pc_fetch u_pc_fetch (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_branch_taken (taken),
        .i_imm          (imm),
        .o_pc           (pc),
        .o_next_pc      (next_pc)
    );

    instr_decode u_instr_decode (
        .i_instr   (i_imem_rdata),
        .o_rs1     (rs1),
        .o_rs2     (rs2),
        .o_rd      (rd),
        .o_rd_wen  (rd_wen),
        .o_use_imm (use_imm),
        .o_alu_op  (alu_op),
        .o_imm_fmt (imm_fmt),
        .o_br_cond (br_cond)
    );

    imm_gen u_imm_gen (
        .i_instr (i_imem_rdata),
        .i_fmt   (imm_fmt),
        .o_imm   (imm)
    );

    //////////////////////////////
    // execute and writeback
    //////////////////////////////

    // the alu result goes straight back to rd since there are no loads
    reg_file u_reg_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .i_rd       (rd),
        .i_wen      (rd_wen),
        .i_wdata    (alu_result),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    // branches compare two registers so only immediate forms pick imm here
    assign operand_b = use_imm ? imm : rs2_data;

    alu u_alu (
        .i_op      (alu_op),
        .i_br_cond (br_cond),
        .i_a       (rs1_data),
        .i_b       (operand_b),
        .o_result  (alu_result),
        .o_taken   (taken)
    );

    // the decoder already reports rd as zero for instructions that do not write
    assign o_imem_raddr      = pc;
    assign o_retire_pc       = pc;
    assign o_retire_next_pc  = next_pc;
    assign o_retire_rd_waddr = rd;
    assign o_retire_rd_wdata = alu_result;

endmodule

// File: tb_hart_core.sv
// tb_hart_core
// directed testbench for the single-cycle core with a register and pc reference model
`include "hart_core_consts.svh"

module tb_hart_core;

    // well over ten times the roughly 150 cycles of the directed sequence
    localparam int unsigned MAX_CYCLES = 2000;
    localparam logic [31:0] NOP = 32'h0000_0013;

    logic               clk;
    logic               rst_n;
    hart_pkg::word_t    i_imem_rdata;
    hart_pkg::word_t    o_imem_raddr;
    hart_pkg::word_t    o_retire_pc;
    hart_pkg::word_t    o_retire_next_pc;
    hart_pkg::reg_idx_t o_retire_rd_waddr;
    hart_pkg::word_t    o_retire_rd_wdata;

    // architectural state as the reference model sees it
    logic [31:0] model_regs [32];
    logic [31:0] model_pc;

    int unsigned check_count;
    int unsigned error_count;
    int unsigned cycle_count;

    hart_core dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .o_imem_raddr      (o_imem_raddr),
        .i_imem_rdata      (i_imem_rdata),
        .o_retire_pc       (o_retire_pc),
        .o_retire_next_pc  (o_retire_next_pc),
        .o_retire_rd_waddr (o_retire_rd_waddr),
        .o_retire_rd_wdata (o_retire_rd_wdata)
    );

    always #20 clk = ~clk;

    // the run ends here if the sequence stalls
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout after %0d cycles without reaching the end", cycle_count);
            $display("Something failed");
            $finish;
        end
    end

    //////////////////////////////
    // instruction encoders
    //////////////////////////////

    function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, `OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] lui_word(input logic [19:0] upper, input logic [4:0] rd);
        return {upper, rd, `OPC_LUI};
    endfunction

    // the offset is in bytes and bit 0 is dropped by the format
    function automatic logic [31:0] branch_word(input logic [12:0] off, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPC_BRANCH};
    endfunction

    // a store word, which this core treats as a no-op
    function automatic logic [31:0] store_word(input logic [11:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b010_0011};
    endfunction

    //////////////////////////////
    // reference model
    //////////////////////////////

    // RV32I arithmetic by funct3, alt picks SUB or SRA
    function automatic logic [31:0] arith_ref(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [4:0]  sh;
        logic        lt;
        logic [31:0] r;
        sh = b[4:0];
        case (f3)
            3'b000: r = alt ? a - b : a + b;
            3'b001: r = a << sh;
            3'b010: begin
                // differing signs decide by the sign of a alone
                lt = (a[31] != b[31]) ? a[31] : (a < b);
                r  = {31'd0, lt};
            end
            3'b011: r = (a < b) ? 32'd1 : 32'd0;
            3'b100: r = a ^ b;
            3'b101: r = alt ? ((a >> sh) | ({32{a[31]}} & ~(32'hFFFF_FFFF >> sh))) : a >> sh;
            3'b110: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        logic lt_s;
        lt_s = (a[31] != b[31]) ? a[31] : (a < b);
        case (f3)
            `F3_BEQ:  return a == b;
            `F3_BNE:  return a != b;
            `F3_BLT:  return lt_s;
            `F3_BGE:  return !lt_s;
            `F3_BLTU: return a < b;
            `F3_BGEU: return a >= b;
            default:  return 1'b0;
        endcase
    endfunction

    task automatic expect_word(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        check_count++;
        assert (act_val === exp_val) else begin
            error_count++;
            $display("FAILED at %0t: %s expected 0x%08h got 0x%08h",
                     $time, name, exp_val, act_val);
        end
    endtask

    // compares the retire outputs with the model, then lets the model retire the instruction
    task automatic retire_check(input logic [31:0] instr);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] exp_wdata;
        logic [31:0] exp_next;
        logic        writes;
        logic        taken;
        opc       = instr[6:0];
        f3        = instr[14:12];
        rd        = instr[11:7];
        a         = model_regs[instr[19:15]];
        b         = model_regs[instr[24:20]];
        imm_i     = {{20{instr[31]}}, instr[31:20]};
        imm_b     = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        writes    = 1'b0;
        taken     = 1'b0;
        exp_wdata = 32'd0;
        if (opc == `OPC_OP) begin
            writes    = 1'b1;
            exp_wdata = arith_ref(f3, instr[30], a, b);
        end else if (opc == `OPC_OP_IMM) begin
            // bit 30 of an immediate only matters for the right shifts
            writes    = 1'b1;
            exp_wdata = arith_ref(f3, instr[30] && (f3 == `F3_SR), a, imm_i);
        end else if (opc == `OPC_LUI) begin
            writes    = 1'b1;
            exp_wdata = {instr[31:12], 12'h000};
        end else if (opc == `OPC_BRANCH) begin
            taken = branch_ref(f3, a, b);
        end
        exp_next = taken ? model_pc + imm_b : model_pc + `PC_STEP;
        expect_word("o_imem_raddr", model_pc, o_imem_raddr);
        expect_word("o_retire_pc", model_pc, o_retire_pc);
        expect_word("o_retire_next_pc", exp_next, o_retire_next_pc);
        expect_word("o_retire_rd_waddr", writes ? 32'(rd) : 32'd0, 32'(o_retire_rd_waddr));
        if (writes) begin
            expect_word("o_retire_rd_wdata", exp_wdata, o_retire_rd_wdata);
        end
        if (writes && rd != 5'd0) begin
            model_regs[rd] = exp_wdata;
        end
        model_pc = exp_next;
    endtask

    // one instruction per cycle, checked half a period after it is presented
    task automatic execute(input logic [31:0] instr);
        @(posedge clk);
        i_imem_rdata <= instr;
        @(negedge clk);
        retire_check(instr);
    endtask

    // ADDI sign-extends its 12 bits so the upper part absorbs bit 11
    task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
        execute(lui_word(value[31:12] + 20'(value[11]), rd));
        execute(i_type_word(value[11:0], rd, `F3_ADD, rd));
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic check_reset_fetch();
        logic [31:0] prev;
        repeat (16) begin
            @(negedge clk);
            expect_word("o_imem_raddr", `RESET_ADDR, o_imem_raddr);
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        expect_word("o_imem_raddr", `RESET_ADDR, o_imem_raddr);
        retire_check(NOP);
        for (int i = 0; i < 4; i++) begin
            prev = o_imem_raddr;
            execute(NOP);
            expect_word("o_imem_raddr", prev + `PC_STEP, o_imem_raddr);
        end
    endtask

    task automatic run_r_ops();
        logic [6:0] f7;
        logic [2:0] f3;
        for (int r = 1; r <= 10; r++) begin
            load_reg(5'(r), $urandom);
        end
        for (int op = 0; op < 10; op++) begin
            f7 = 7'h00;
            case (op)
                0: f3 = `F3_ADD;
                1: begin
                    f7 = 7'h20;
                    f3 = `F3_ADD;
                end
                2: f3 = `F3_SLL;
                3: f3 = `F3_SLT;
                4: f3 = `F3_SLTU;
                5: f3 = `F3_XOR;
                6: f3 = `F3_SR;
                7: begin
                    f7 = 7'h20;
                    f3 = `F3_SR;
                end
                8: f3 = `F3_OR;
                default: f3 = `F3_AND;
            endcase
            repeat (4) begin
                execute(r_type_word(f7, 5'($urandom_range(10, 1)), 5'($urandom_range(10, 1)),
                                    f3, 5'($urandom_range(20, 11))));
            end
        end
    endtask

    task automatic run_i_ops();
        logic [11:0] imm;
        logic [2:0]  f3;
        for (int op = 0; op < 9; op++) begin
            repeat (4) begin
                imm = 12'($urandom);
                case (op)
                    0: f3 = `F3_ADD;
                    1: f3 = `F3_SLT;
                    2: f3 = `F3_SLTU;
                    3: f3 = `F3_XOR;
                    4: f3 = `F3_OR;
                    5: f3 = `F3_AND;
                    6: begin
                        f3  = `F3_SLL;
                        imm = {7'h00, imm[4:0]};
                    end
                    7: begin
                        f3  = `F3_SR;
                        imm = {7'h00, imm[4:0]};
                    end
                    default: begin
                        f3  = `F3_SR;
                        imm = {7'h20, imm[4:0]};
                    end
                endcase
                execute(i_type_word(imm, 5'($urandom_range(10, 1)), f3,
                                    5'($urandom_range(20, 11))));
            end
        end
    endtask

    task automatic check_lui_x0();
        logic [19:0] upper;
        upper = 20'($urandom);
        execute(lui_word(upper, 5'd26));
        expect_word("o_retire_rd_wdata", {upper, 12'h000}, o_retire_rd_wdata);
        // writes aimed at x0 must leave it reading zero
        execute(lui_word(20'($urandom), 5'd0));
        execute(i_type_word(12'h123, 5'd1, `F3_ADD, 5'd0));
        execute(r_type_word(7'h00, 5'd2, 5'd0, `F3_ADD, 5'd27));
        execute(r_type_word(7'h00, 5'd0, 5'd0, `F3_ADD, 5'd28));
        expect_word("o_retire_rd_wdata", 32'd0, o_retire_rd_wdata);
    endtask

    task automatic run_branch(input logic [2:0] f3, input logic [4:0] rs1,
                              input logic [4:0] rs2, input logic exp_taken);
        logic [12:0] off;
        logic [31:0] exp_next;
        off      = 13'($urandom) & 13'h1FFE;
        exp_next = exp_taken ? model_pc + {{19{off[12]}}, off} : model_pc + `PC_STEP;
        execute(branch_word(off, rs2, rs1, f3));
        expect_word("o_retire_next_pc", exp_next, o_retire_next_pc);
    endtask

    // x21 is negative, x22 and x23 hold the same small positive value
    task automatic run_branches();
        load_reg(5'd21, 32'hFFFF_FFFB);
        load_reg(5'd22, 32'd7);
        load_reg(5'd23, 32'd7);
        run_branch(`F3_BEQ, 5'd22, 5'd23, 1'b1);
        run_branch(`F3_BEQ, 5'd21, 5'd22, 1'b0);
        run_branch(`F3_BNE, 5'd21, 5'd22, 1'b1);
        run_branch(`F3_BNE, 5'd22, 5'd23, 1'b0);
        run_branch(`F3_BLT, 5'd21, 5'd22, 1'b1);
        run_branch(`F3_BLT, 5'd22, 5'd21, 1'b0);
        run_branch(`F3_BGE, 5'd22, 5'd21, 1'b1);
        run_branch(`F3_BGE, 5'd21, 5'd22, 1'b0);
        run_branch(`F3_BLTU, 5'd22, 5'd21, 1'b1);
        run_branch(`F3_BLTU, 5'd21, 5'd22, 1'b0);
        run_branch(`F3_BGEU, 5'd21, 5'd22, 1'b1);
        run_branch(`F3_BGEU, 5'd22, 5'd21, 1'b0);
        // the first fetch after the last branch lands on its target
        execute(NOP);
    endtask

    // the store's low immediate bits sit where rd would be, pointing at x31
    task automatic check_unsupported();
        logic [31:0] saved;
        saved = $urandom;
        load_reg(5'd31, saved);
        execute(store_word(12'h01F, 5'd2, 5'd1));
        expect_word("o_retire_rd_waddr", 32'd0, 32'(o_retire_rd_waddr));
        execute(r_type_word(7'h00, 5'd0, 5'd31, `F3_ADD, 5'd30));
        expect_word("o_retire_rd_wdata", saved, o_retire_rd_wdata);
    endtask

    initial begin
        void'($urandom(32'h3fd9fbe0));
        clk          = 1'b0;
        rst_n        <= 1'b0;
        i_imem_rdata <= NOP;
        check_count  = 0;
        error_count  = 0;
        cycle_count  = 0;
        model_pc     = `RESET_ADDR;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'd0;
        end

        check_reset_fetch();
        run_r_ops();
        run_i_ops();
        check_lui_x0();
        run_branches();
        check_unsupported();

        $display("checks %0d errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: hart_core.f
+incdir+.
hart_pkg.sv
pc_fetch.sv
instr_decode.sv
imm_gen.sv
reg_file.sv
alu.sv
hart_core.sv
tb_hart_core.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_hart_core -f hart_core.f -o sim_hart_core
./obj_dir/sim_hart_core > sim.log
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failures"
